//--- logic/permDataPkg.sv
package permDataPkg;

    // a top or a bot, as sent by the host in two 64-bit halves
    localparam int wordWidth = 128;
    localparam int sumWidth = 48;
    localparam int countWidth = 15;
    localparam int resultWidth = 64;

    // bit 63 of a result word tells a bot result from a top report
    localparam logic kindBot = 1'b1;
    localparam logic kindTop = 1'b0;

    // top report payload below the kind bit
    localparam int activityWidth = 31;
    localparam int cycleWidth = 32;
    localparam int reportWidth = activityWidth + cycleWidth;

    typedef struct packed {
        logic [countWidth-1:0] count;
        logic [sumWidth-1:0] sum;
    } resultT;

endpackage

//--- logic/permFlowPkg.sv
package permFlowPkg;

    // scoring latency in cycles, one valid bit per stage
    localparam int pipeDepth = 4;

    // enough bits to count every stage as busy at once
    localparam int occupancyWidth = $clog2(pipeDepth + 1);

    // which peer owns the next word on the result bus
    typedef enum logic {
        originTop = 1'b0,
        originBot = 1'b1
    } originT;

endpackage

//--- logic/syncFifo.sv
`timescale 1ns/100ps

module syncFifo #(
    parameter type payloadT = logic,
    parameter int DEPTH = 8,
    parameter int MARGIN = 2
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    writeEnable,
    input  payloadT dataIn,
    input  logic    readEnable,
    output payloadT dataOut,
    output logic    empty,
    output logic    almostFull
);
    localparam int ptrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int fillWidth = $clog2(DEPTH + 1);

    payloadT mem [DEPTH];
    logic [ptrWidth-1:0] writePtr;
    logic [ptrWidth-1:0] readPtr;
    logic [fillWidth-1:0] fillCount;
    logic full;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            fillCount <= '0;
        end else begin
            if (writeEnable) begin
                writePtr <= (writePtr == ptrWidth'(DEPTH - 1)) ? '0 : writePtr + 1'b1;
            end
            if (readEnable) begin
                readPtr <= (readPtr == ptrWidth'(DEPTH - 1)) ? '0 : readPtr + 1'b1;
            end
            if (writeEnable && !readEnable) begin
                fillCount <= fillCount + 1'b1;
            end else if (readEnable && !writeEnable) begin
                fillCount <= fillCount - 1'b1;
            end
        end
    end

    // head word is visible before the read strobe
    assign dataOut = mem[readPtr];
    assign empty = (fillCount == '0);
    assign full = (fillCount == fillWidth'(DEPTH));
    assign almostFull = (int'(fillCount) >= DEPTH - MARGIN);

    // upstream must stop early enough that words in flight still fit
    noOverflow: assert property (@(posedge clk) disable iff (rst) writeEnable |-> !full);
    noUnderflow: assert property (@(posedge clk) disable iff (rst) readEnable |-> !empty);

endmodule

//--- logic/resetNormalizer.sv
`timescale 1ns/100ps

module resetNormalizer #(
    parameter int RESET_STRETCH = 8
) (
    input  logic clk,
    input  logic resetn,
    output logic rst,
    output logic isInitialized
);
    localparam int stretchWidth = (RESET_STRETCH > 1) ? $clog2(RESET_STRETCH) : 1;

    logic [stretchWidth-1:0] stretchCount;

    // one register stage turns the port reset into an internal active-high reset
    always_ff @(posedge clk) begin
        rst <= !resetn;
    end

    // keep the design marked as not ready for a while after reset leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            stretchCount <= '0;
            isInitialized <= 1'b0;
        end else if (stretchCount == stretchWidth'(RESET_STRETCH - 1)) begin
            isInitialized <= 1'b1;
        end else begin
            stretchCount <= stretchCount + 1'b1;
        end
    end

endmodule

//--- logic/topManager.sv
`timescale 1ns/100ps

module topManager (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            writeTop,
    input  logic [permDataPkg::wordWidth-1:0] topIn,
    input  logic                            pendingZero,
    output logic                            stallInput,
    output logic [permDataPkg::wordWidth-1:0] currentTop
);
    logic [$bits(topIn)-1:0] pendingTop;

    // new top waits here while older results drain
    always_ff @(posedge clk) begin
        if (writeTop) begin
            pendingTop <= topIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stallInput <= 1'b0;
        end else if (writeTop) begin
            stallInput <= 1'b1;
        end else if (pendingZero) begin
            stallInput <= 1'b0;
        end
    end

    // swap only once nothing older is outstanding
    always_ff @(posedge clk) begin
        if (stallInput && pendingZero) begin
            currentTop <= pendingTop;
        end
    end

endmodule

//--- logic/permutationPipeline.sv
`timescale 1ns/100ps

module permutationPipeline (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     writeBot,
    input  logic [permDataPkg::wordWidth-1:0]        bot,
    input  logic [permDataPkg::wordWidth-1:0]        top,
    input  logic                                     slowDown,
    output logic                                     readyForInput,
    output logic                                     resultValid,
    output permDataPkg::resultT                      result,
    output logic [permFlowPkg::occupancyWidth-1:0]   activityMeasure
);
    import permDataPkg::*;
    import permFlowPkg::*;

    localparam int laneCount = wordWidth / 8;
    localparam int groupCount = 4;
    localparam int lanesPerGroup = laneCount / groupCount;
    localparam int prodWidth = 16;
    localparam int partWidth = prodWidth + $clog2(lanesPerGroup);
    localparam int totalWidth = partWidth + $clog2(groupCount);
    localparam int popWidth = $clog2(wordWidth + 1);

    logic [pipeDepth-1:0] stageValid;
    logic [wordWidth-1:0] andWord1;
    logic [prodWidth-1:0] prod1 [laneCount];
    logic [partWidth-1:0] partNext [groupCount];
    logic [partWidth-1:0] part2 [groupCount];
    logic [popWidth-1:0] count2;
    logic [popWidth-1:0] count3;
    logic [totalWidth-1:0] sumNext;
    logic [totalWidth-1:0] sum3;

    function automatic logic [popWidth-1:0] popCount(input logic [wordWidth-1:0] w);
        logic [popWidth-1:0] n;
        n = '0;
        for (int i = 0; i < wordWidth; i++) begin
            n = n + popWidth'(w[i]);
        end
        return n;
    endfunction

    // full output FIFO throttles the input, stages already running keep going
    assign readyForInput = !slowDown;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[pipeDepth-2:0], writeBot};
        end
    end

    // stage 1: lane AND and byte products
    always_ff @(posedge clk) begin
        andWord1 <= top & bot;
        for (int i = 0; i < laneCount; i++) begin
            prod1[i] <= top[8*i +: 8] * bot[8*i +: 8];
        end
    end

    always_comb begin
        for (int g = 0; g < groupCount; g++) begin
            partNext[g] = '0;
            for (int j = 0; j < lanesPerGroup; j++) begin
                partNext[g] = partNext[g] + partWidth'(prod1[g*lanesPerGroup + j]);
            end
        end
    end

    // stage 2: group sums and popcount
    always_ff @(posedge clk) begin
        part2 <= partNext;
        count2 <= popCount(andWord1);
    end

    always_comb begin
        sumNext = '0;
        for (int g = 0; g < groupCount; g++) begin
            sumNext = sumNext + totalWidth'(part2[g]);
        end
    end

    // stage 3: total sum
    always_ff @(posedge clk) begin
        sum3 <= sumNext;
        count3 <= count2;
    end

    // stage 4: widen into the result fields
    always_ff @(posedge clk) begin
        result.count <= countWidth'(count3);
        result.sum <= sumWidth'(sum3);
    end

    assign resultValid = stageValid[pipeDepth-1];

    always_comb begin
        activityMeasure = '0;
        for (int s = 0; s < pipeDepth; s++) begin
            activityMeasure = activityMeasure + occupancyWidth'(stageValid[s]);
        end
    end

    // the top level must honour the FIFO back-pressure
    botWhenReady: assert property (@(posedge clk) disable iff (rst) writeBot |-> readyForInput);

endmodule

//--- logic/topReport.sv
`timescale 1ns/100ps

module topReport (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   grab,
    input  logic [permFlowPkg::occupancyWidth-1:0] activityMeasure,
    output logic [permDataPkg::reportWidth-1:0]    report
);
    import permDataPkg::*;

    logic [cycleWidth-1:0] cycleCount;
    logic [activityWidth-1:0] activitySum;

    // both counters restart when the host takes a report
    always_ff @(posedge clk) begin
        if (rst || grab) begin
            cycleCount <= '0;
            activitySum <= '0;
        end else begin
            cycleCount <= cycleCount + 1'b1;
            activitySum <= activitySum + activityWidth'(activityMeasure);
        end
    end

    // occupancy is activitySum / (pipeDepth * cycleCount) on the host side
    assign report = {activitySum, cycleCount};

endmodule

//--- logic/resultArbiter.sv
`timescale 1ns/100ps

module resultArbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                iready,
    input  permFlowPkg::originT                 headOrigin,
    input  logic                                originEmpty,
    input  logic                                fifoEmpty,
    input  permDataPkg::resultT                 fifoData,
    input  logic [permDataPkg::reportWidth-1:0] report,
    output logic                                ovalid,
    output logic [permDataPkg::resultWidth-1:0] summedDataPcoeffCountOut,
    output logic                                popOrigin,
    output logic                                popResult,
    output logic                                grabReport
);
    import permDataPkg::*;
    import permFlowPkg::*;

    logic transfer;

    // a report is always ready and a bot result only once it reached the FIFO
    assign ovalid = !originEmpty && ((headOrigin == originTop) || !fifoEmpty);
    assign transfer = ovalid && iready;

    assign popOrigin = transfer;
    assign popResult = transfer && (headOrigin == originBot);
    assign grabReport = transfer && (headOrigin == originTop);

    always_comb begin
        if (headOrigin == originBot) begin
            summedDataPcoeffCountOut = {kindBot, fifoData.count, fifoData.sum};
        end else begin
            summedDataPcoeffCountOut = {kindTop, report};
        end
    end

    // a presented word stays on the bus until the host takes it
    holdUntilTaken: assert property (@(posedge clk) disable iff (rst)
        ovalid && !iready |=> ovalid);

endmodule

//--- logic/permutationTop.sv
`timescale 1ns/100ps

module permutationTop #(
    parameter int ORIGIN_DEPTH = 16,
    parameter int RESULT_DEPTH = 8,
    parameter int ALMOST_FULL_MARGIN = 5,
    parameter int RESET_STRETCH = 8
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  ivalid,
    input  logic                                  iready,
    input  logic                                  startNewTop,
    input  logic [permDataPkg::wordWidth/2-1:0]   botLower,
    input  logic [permDataPkg::wordWidth/2-1:0]   botUpper,
    output logic                                  ovalid,
    output logic                                  oready,
    output logic [permDataPkg::resultWidth-1:0]   summedDataPcoeffCountOut
);
    import permDataPkg::*;
    import permFlowPkg::*;

    localparam int pendingWidth = $clog2(ORIGIN_DEPTH + 1);

    logic rst;
    logic isInitialized;
    logic [wordWidth-1:0] stagedWord;
    logic botStaged;
    logic topStaged;
    logic pipeReady;
    logic stallInput;
    logic readyForInput;
    logic writeBot;
    logic writeTop;
    logic [wordWidth-1:0] currentTop;
    logic [pendingWidth-1:0] pendingCount;
    logic pendingZero;
    logic resultValid;
    resultT pipeResult;
    logic [occupancyWidth-1:0] activityMeasure;
    logic slowDown;
    resultT fifoData;
    logic fifoEmpty;
    originT originIn;
    originT headOrigin;
    logic originEmpty;
    logic popOrigin;
    logic popResult;
    logic grabReport;
    logic [reportWidth-1:0] report;

    resetNormalizer #(.RESET_STRETCH(RESET_STRETCH)) u_resetNormalizer (
        .clk(clk), .resetn(resetn), .rst(rst), .isInitialized(isInitialized)
    );

    // one-deep staging lets oready rise before initialization finishes
    always_ff @(posedge clk) begin
        if (oready) begin
            stagedWord <= {botUpper, botLower};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            botStaged <= 1'b0;
            topStaged <= 1'b0;
        end else if (oready) begin
            botStaged <= ivalid && !startNewTop;
            topStaged <= ivalid && startNewTop;
        end
    end

    assign readyForInput = pipeReady && !stallInput;
    assign oready = (readyForInput && isInitialized) || (!botStaged && !topStaged && !rst);
    assign writeBot = botStaged && oready;
    assign writeTop = topStaged && oready;
    assign originIn = writeTop ? originTop : originBot;

    // results accepted but not yet read by the host
    always_ff @(posedge clk) begin
        if (rst) begin
            pendingCount <= '0;
        end else if ((writeBot || writeTop) && !popOrigin) begin
            pendingCount <= pendingCount + 1'b1;
        end else if (popOrigin && !(writeBot || writeTop)) begin
            pendingCount <= pendingCount - 1'b1;
        end
    end

    assign pendingZero = (pendingCount == '0);

    topManager u_topManager (
        .clk(clk), .rst(rst), .writeTop(writeTop), .topIn(stagedWord),
        .pendingZero(pendingZero), .stallInput(stallInput), .currentTop(currentTop)
    );

    permutationPipeline u_permutationPipeline (
        .clk(clk), .rst(rst), .writeBot(writeBot), .bot(stagedWord), .top(currentTop),
        .slowDown(slowDown), .readyForInput(pipeReady), .resultValid(resultValid),
        .result(pipeResult), .activityMeasure(activityMeasure)
    );

    topReport u_topReport (
        .clk(clk), .rst(rst), .grab(grabReport), .activityMeasure(activityMeasure),
        .report(report)
    );

    syncFifo #(.payloadT(originT), .DEPTH(ORIGIN_DEPTH), .MARGIN(ALMOST_FULL_MARGIN)) originQueue (
        .clk(clk), .rst(rst), .writeEnable(writeBot || writeTop), .dataIn(originIn),
        .readEnable(popOrigin), .dataOut(headOrigin), .empty(originEmpty), .almostFull()
    );

    syncFifo #(.payloadT(resultT), .DEPTH(RESULT_DEPTH), .MARGIN(ALMOST_FULL_MARGIN)) resultFifo (
        .clk(clk), .rst(rst), .writeEnable(resultValid), .dataIn(pipeResult),
        .readEnable(popResult), .dataOut(fifoData), .empty(fifoEmpty), .almostFull(slowDown)
    );

    resultArbiter u_resultArbiter (
        .clk(clk), .rst(rst), .iready(iready), .headOrigin(headOrigin),
        .originEmpty(originEmpty), .fifoEmpty(fifoEmpty), .fifoData(fifoData),
        .report(report), .ovalid(ovalid), .summedDataPcoeffCountOut(summedDataPcoeffCountOut),
        .popOrigin(popOrigin), .popResult(popResult), .grabReport(grabReport)
    );

endmodule

//--- bench/clockGen.sv
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic resetn
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = !clk;
    end

    // reset seen on two rising edges, released on a falling edge
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

//--- bench/permBench.sv
`timescale 1ns/100ps

module permBench;
    import permDataPkg::*;
    import permFlowPkg::*;

    localparam int waitLimit = 300;

    logic clk;
    logic resetn;
    logic ivalid;
    logic iready;
    logic startNewTop;
    logic [wordWidth/2-1:0] botLower;
    logic [wordWidth/2-1:0] botUpper;
    logic ovalid;
    logic oready;
    logic [resultWidth-1:0] summedDataPcoeffCountOut;

    // words still to offer and results the host still expects in order
    logic [wordWidth-1:0] sendWord [$];
    bit sendIsTop [$];
    bit expIsBot [$];
    logic [countWidth-1:0] expCount [$];
    logic [sumWidth-1:0] expSum [$];

    logic [wordWidth-1:0] modelTop;
    logic [31:0] rngState;
    logic sawOready;
    logic sawOvalid;
    logic [activityWidth-1:0] lastActivity;

    clockGen u_clockGen (.clk(clk), .resetn(resetn));

    permutationTop #(
        .ORIGIN_DEPTH(16), .RESULT_DEPTH(8), .ALMOST_FULL_MARGIN(5), .RESET_STRETCH(8)
    ) u_permutationTop (
        .clk(clk), .resetn(resetn), .ivalid(ivalid), .iready(iready),
        .startNewTop(startNewTop), .botLower(botLower), .botUpper(botUpper),
        .ovalid(ovalid), .oready(oready), .summedDataPcoeffCountOut(summedDataPcoeffCountOut)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [wordWidth-1:0] randomWord();
        logic [wordWidth-1:0] w;
        for (int i = 0; i < wordWidth / 32; i++) begin
            w[32*i +: 32] = nextRandom();
        end
        return w;
    endfunction

    // popcount of top AND bot
    function automatic logic [countWidth-1:0] modelCount(input logic [wordWidth-1:0] t,
                                                         input logic [wordWidth-1:0] b);
        logic [countWidth-1:0] n;
        n = '0;
        for (int i = 0; i < wordWidth; i++) begin
            if (t[i] && b[i]) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // sum of byte-lane products
    function automatic logic [sumWidth-1:0] modelSum(input logic [wordWidth-1:0] t,
                                                     input logic [wordWidth-1:0] b);
        logic [sumWidth-1:0] s;
        s = '0;
        for (int lane = 0; lane < wordWidth / 8; lane++) begin
            s = s + sumWidth'(t[8*lane +: 8]) * sumWidth'(b[8*lane +: 8]);
        end
        return s;
    endfunction

    // queue a word and predict its result against the top in force at that point
    task automatic planWord(input logic [wordWidth-1:0] w, input bit isTop);
        sendWord.push_back(w);
        sendIsTop.push_back(isTop);
        expIsBot.push_back(!isTop);
        if (isTop) begin
            modelTop = w;
            expCount.push_back('0);
            expSum.push_back('0);
        end else begin
            expCount.push_back(modelCount(modelTop, w));
            expSum.push_back(modelSum(modelTop, w));
        end
    endtask

    task automatic checkResult(input logic [resultWidth-1:0] word);
        bit isBot;
        logic [countWidth-1:0] cnt;
        logic [sumWidth-1:0] sum;
        logic [activityWidth-1:0] activity;
        logic [cycleWidth-1:0] cycles;
        assert (expIsBot.size() > 0) else
            failRun($sformatf("ERROR at time %0t: unexpected result word %h", $time, word));
        isBot = expIsBot.pop_front();
        cnt = expCount.pop_front();
        sum = expSum.pop_front();
        assert (word[63] == isBot) else
            failRun($sformatf("ERROR at time %0t: kind %b, expected %b", $time, word[63], isBot));
        if (isBot) begin
            assert (word[62:48] == cnt) else
                failRun($sformatf("ERROR at time %0t: count %0d, expected %0d",
                                  $time, word[62:48], cnt));
            assert (word[47:0] == sum) else
                failRun($sformatf("ERROR at time %0t: sum %0d, expected %0d",
                                  $time, word[47:0], sum));
        end else begin
            activity = word[62:32];
            cycles = word[31:0];
            assert (cycles != 0) else
                failRun($sformatf("ERROR at time %0t: report with zero cycle count", $time));
            assert (64'(activity) <= 64'(pipeDepth) * 64'(cycles)) else
                failRun($sformatf("ERROR at time %0t: activity %0d over bound for %0d cycles",
                                  $time, activity, cycles));
            lastActivity = activity;
        end
    endtask

    // one clock of sampling settled outputs and then driving the next inputs
    task automatic stepCycle(input bit holdOutput);
        logic [resultWidth-1:0] word;
        @(negedge clk);
        sawOready = oready;
        sawOvalid = ovalid;
        word = summedDataPcoeffCountOut;
        iready = !holdOutput;
        if (sendWord.size() > 0) begin
            ivalid = 1'b1;
            startNewTop = sendIsTop[0];
            {botUpper, botLower} = sendWord[0];
            if (sawOready) begin
                sendWord.delete(0);
                sendIsTop.delete(0);
            end
        end else begin
            ivalid = 1'b0;
            startNewTop = 1'b0;
        end
        if (sawOvalid && !holdOutput) begin
            checkResult(word);
        end
    endtask

    task automatic drainAll();
        int cycles;
        cycles = 0;
        while ((sendWord.size() > 0 || expIsBot.size() > 0) && cycles < waitLimit) begin
            stepCycle(1'b0);
            cycles++;
        end
        assert (sendWord.size() == 0 && expIsBot.size() == 0) else
            failRun($sformatf("timeout: %0d words unsent, %0d results missing",
                              sendWord.size(), expIsBot.size()));
        // nothing more may appear once every expected word was read
        repeat (pipeDepth + 2) begin
            stepCycle(1'b0);
        end
    endtask

    task automatic resetStateTest();
        int waited;
        waited = 0;
        while (resetn !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        assert (resetn === 1'b1) else failRun("timeout: reset was never released");
        @(negedge clk);
        assert (ovalid === 1'b0) else
            failRun($sformatf("ERROR at time %0t: ovalid is %b after reset", $time, ovalid));
        waited = 0;
        while (oready !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        assert (oready === 1'b1) else failRun("timeout: oready never rose after reset");
    endtask

    task automatic topReportTest();
        planWord(randomWord(), 1'b1);
        drainAll();
    endtask

    task automatic botScoringTest();
        for (int i = 0; i < 20; i++) begin
            planWord(randomWord(), 1'b0);
        end
        drainAll();
    endtask

    // the report sits between the two groups in the expected order
    task automatic topChangeTest();
        for (int i = 0; i < 5; i++) begin
            planWord(randomWord(), 1'b0);
        end
        planWord(randomWord(), 1'b1);
        for (int i = 0; i < 5; i++) begin
            planWord(randomWord(), 1'b0);
        end
        drainAll();
    endtask

    task automatic backPressureTest();
        int waited;
        for (int i = 0; i < 12; i++) begin
            planWord(randomWord(), 1'b0);
        end
        waited = 0;
        sawOready = 1'b1;
        while (sawOready && waited < 50) begin
            stepCycle(1'b1);
            waited++;
        end
        assert (!sawOready) else failRun("timeout: oready stayed high with iready held low");
        repeat (8) stepCycle(1'b1);
        assert (sawOvalid && !sawOready) else
            failRun($sformatf("ERROR at time %0t: ovalid %b oready %b while held",
                              $time, sawOvalid, sawOready));
        drainAll();
    endtask

    // every bot adds one per stage to the next report's activity
    task automatic occupancyTest();
        planWord(randomWord(), 1'b1);
        for (int i = 0; i < 8; i++) begin
            planWord(randomWord(), 1'b0);
        end
        planWord(randomWord(), 1'b1);
        drainAll();
        assert (lastActivity == activityWidth'(pipeDepth * 8)) else
            failRun($sformatf("ERROR at time %0t: activity %0d, expected %0d",
                              $time, lastActivity, pipeDepth * 8));
    endtask

    initial begin
        ivalid = 1'b0;
        iready = 1'b0;
        startNewTop = 1'b0;
        botLower = '0;
        botUpper = '0;
        rngState = 32'hb1ee_1d97;
        modelTop = '0;
        sawOready = 1'b0;
        sawOvalid = 1'b0;
        lastActivity = '0;
        resetStateTest();
        topReportTest();
        botScoringTest();
        topChangeTest();
        backPressureTest();
        occupancyTest();
        if (sendWord.size() == 0 && expIsBot.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            failRun("results were left over at the end of the run");
        end
    end

endmodule

//--- sim.f
logic/permDataPkg.sv
logic/permFlowPkg.sv
logic/syncFifo.sv
logic/resetNormalizer.sv
logic/topManager.sv
logic/permutationPipeline.sv
logic/topReport.sv
logic/resultArbiter.sv
logic/permutationTop.sv
bench/clockGen.sv
bench/permBench.sv
